//--- tb.f
source/heapPkg.sv
source/heapBus.sv
source/arrayAllocator.sv
source/arraySizeTable.sv
source/elementStore.sv
source/arrayHeap.sv
verif/heapTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the array heap testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module heapTb -o heapSim \
  && output="$(./obj_dir/heapSim)" \
  && echo "$output" \
  && grep -q "ALL TESTS PASSED" <<< "$output" \
  || { echo "Simulation did not pass"; exit 1; }

//--- verif/heapTb.sv
`timescale 1ns/1ns
`default_nettype none
// Testbench for the array heap with a reference model and a Wishbone master
// Only one request in flight; the model only reads elements that were written
// Concurrent assertions compare every ack against the model

module heapTb;

  import heapPkg::*;

  // --------------------------------------------------
  // Run limits and stimulus
  // --------------------------------------------------
  localparam int clockPeriod     = 20;
  localparam int arrayLimit      = 8;
  localparam int plannedRequests = 140;           // Upper bound over all tests
  localparam int timeoutCycles   = plannedRequests * 4 + 40;

  logic        clock;
  logic        reset;
  wbRequest    request;
  wbResponse   response;
  int          seed = 32'h748b0d45;
  int          errorCount;
  int          requestCount;
  logic        busy;                              // Request sampled and ack not yet seen
  logic        sampleEdge;
  logic [15:0] expData;                           // Model's reply for the open request
  heapStatus   expStatus;

  // Reference model state
  logic        modelLive [arrayCount];
  int          modelSize [arrayCount];
  logic [15:0] modelMem  [arrayCount][arrayLength];
  int          freeList  [$];                     // Freed numbers with the newest at the back
  int          nextFresh;

  arrayHeap #(
    .arrayLimit (arrayLimit)
  ) i_arrayHeap (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .response (response)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  initial begin
    #(timeoutCycles * clockPeriod);
    $display("Watchdog expired after %0d cycles, the DUT stopped answering", timeoutCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Handshake and reply assertions
  // --------------------------------------------------
  assign sampleEdge = !reset && request.cyc && request.stb && !response.ack && !busy;

  always @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (sampleEdge) begin
      busy <= 1'b1;
    end else if (response.ack) begin
      busy <= 1'b0;                               // Ready for the next request
    end
  end

  ackTiming: assert property (@(posedge clock) disable iff (reset)
      response.ack == $past(sampleEdge, 2))
    else begin
      errorCount++;
      $display("ERR %0t: ack is not exactly one cycle after sampling", $time);
    end

  ackPulse: assert property (@(posedge clock) disable iff (reset)
      response.ack |=> !response.ack)
    else begin
      errorCount++;
      $display("ERR %0t: ack lasts more than one cycle", $time);
    end

  ackReset: assert property (@(posedge clock) reset |=> !response.ack)
    else begin
      errorCount++;
      $display("ERR %0t: ack high after reset", $time);
    end

  replyMatch: assert property (@(posedge clock) disable iff (reset)
      response.ack |-> (response.data == expData && response.status == expStatus))
    else begin
      errorCount++;
      $display("ERR %0t: reply %0h status %0d, model %0h status %0d", $time,
               response.data, response.status, expData, expStatus);
    end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [15:0] combine(input heapOp op, input logic [15:0] a,
                                          input logic [15:0] b);
    case (op)
      opAdd:   return a + b;                      // Wraps at 16 bits
      opSub:   return a - b;
      opAnd:   return a & b;
      opOr:    return a | b;
      default: return a ^ b;
    endcase
  endfunction

  task automatic modelStep(input heapOp op, input int arr, input int idx,
                           input logic [15:0] value, output logic [15:0] data,
                           output heapStatus status);
    int pick;
    pick   = 0;
    data   = '0;                                  // Errors carry no payload
    status = stOk;
    if (op == opAlloc) begin
      if (freeList.size() != 0) begin
        pick = freeList.pop_back();               // Latest freed first
      end else if (nextFresh < arrayLimit) begin
        pick = nextFresh;
        nextFresh++;
      end else begin
        status = stOutOfMemory;
      end
      if (status == stOk) begin
        modelLive[pick] = 1'b1;
        modelSize[pick] = 0;
        data            = 16'(pick);
      end
    end else if (!modelLive[arr]) begin
      status = stNotAllocated;                    // Model left untouched
    end else begin
      case (op)
        opFree: begin
          modelLive[arr] = 1'b0;
          freeList.push_back(arr);
        end
        opWrite: begin
          modelMem[arr][idx] = value;
          if (idx + 1 > modelSize[arr]) modelSize[arr] = idx + 1;
          data = value;
        end
        opRead: begin
          if (idx >= modelSize[arr]) status = stOutOfBounds;
          else data = modelMem[arr][idx];
        end
        opSize: data = 16'(modelSize[arr]);
        opPush: begin
          if (modelSize[arr] == arrayLength) begin
            status = stFull;
          end else begin
            modelMem[arr][modelSize[arr]] = value;
            modelSize[arr]++;                     // Push itself replies zero
          end
        end
        opPop: begin
          if (modelSize[arr] == 0) begin
            status = stEmpty;
          end else begin
            modelSize[arr]--;
            data = modelMem[arr][modelSize[arr]];
          end
        end
        default: begin
          if (idx >= modelSize[arr]) begin
            status = stOutOfBounds;
          end else begin
            modelMem[arr][idx] = combine(op, modelMem[arr][idx], value);
            data               = modelMem[arr][idx];
          end
        end
      endcase
    end
  endtask

  // --------------------------------------------------
  // Wishbone master and explicit checks
  // --------------------------------------------------
  task automatic busRequest(input heapOp op, input int arr, input int idx,
                            input logic [15:0] value, output logic [15:0] data,
                            output heapStatus status);
    @(posedge clock);
    #2;
    modelStep(op, arr, idx, value, expData, expStatus);  // Previous ack already checked
    request.cyc = 1'b1;
    request.stb = 1'b1;
    request.we  = !(op inside {opRead, opSize});
    request.adr = '{op: op, array: arrayBits'(arr), index: indexBits'(idx)};
    request.data = value;
    do begin
      @(posedge clock);
      #2;
    end while (!response.ack);                    // Watchdog bounds this wait
    data   = response.data;
    status = response.status;
    request.cyc = 1'b0;
    request.stb = 1'b0;
    request.we  = 1'b0;
    requestCount++;
  endtask

  task automatic confirmReply(input string what, input logic [15:0] gotData,
                              input heapStatus gotStatus, input logic [15:0] wantData,
                              input heapStatus wantStatus);
    assert (gotData == wantData && gotStatus == wantStatus) else begin
      errorCount++;
      $display("ERR %0t: %s gave %0h status %0d, expected %0h status %0d", $time,
               what, gotData, gotStatus, wantData, wantStatus);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic allocationOrder();
    logic [15:0] data;
    heapStatus   status;
    for (int n = 0; n < arrayLimit; n++) begin
      busRequest(opAlloc, 0, 0, '0, data, status);
      confirmReply("alloc", data, status, 16'(n), stOk);
    end
    busRequest(opAlloc, 0, 0, '0, data, status);  // Memory exhausted
    confirmReply("alloc when full", data, status, '0, stOutOfMemory);
    busRequest(opFree, 5, 0, '0, data, status);
    busRequest(opFree, 2, 0, '0, data, status);
    busRequest(opAlloc, 0, 0, '0, data, status);
    confirmReply("realloc", data, status, 16'd2, stOk);  // LIFO reuse
    busRequest(opAlloc, 0, 0, '0, data, status);
    confirmReply("realloc", data, status, 16'd5, stOk);
  endtask

  task automatic writeAndRead();
    logic [15:0] data;
    heapStatus   status;
    busRequest(opWrite, 0, 2, 16'($random(seed)), data, status);  // Size becomes 3
    busRequest(opSize, 0, 0, '0, data, status);
    busRequest(opRead, 0, 2, '0, data, status);
    busRequest(opRead, 0, 3, '0, data, status);   // At the size
    confirmReply("read at size", data, status, '0, stOutOfBounds);
    busRequest(opRead, 0, 7, '0, data, status);
    for (int i = 0; i < arrayLength; i++) begin
      busRequest(opWrite, 0, i, 16'($random(seed)), data, status);
      busRequest(opSize, 0, 0, '0, data, status);
      confirmReply("size after write", data, status, 16'(i < 2 ? 3 : i + 1), stOk);
    end
    for (int i = 0; i < arrayLength; i++) begin
      busRequest(opRead, 0, i, '0, data, status);
    end
  endtask

  task automatic pushAndPop();
    logic [15:0] pushed [arrayLength];
    logic [15:0] data;
    heapStatus   status;
    for (int i = 0; i < arrayLength; i++) begin
      pushed[i] = 16'($random(seed));
      busRequest(opPush, 1, 0, pushed[i], data, status);
    end
    busRequest(opPush, 1, 0, 16'hbeef, data, status);
    confirmReply("push when full", data, status, '0, stFull);
    for (int i = arrayLength - 1; i >= 0; i--) begin
      busRequest(opPop, 1, 0, '0, data, status);
      confirmReply("pop", data, status, pushed[i], stOk);  // Reverse order
    end
    busRequest(opPop, 1, 0, '0, data, status);
    confirmReply("pop when empty", data, status, '0, stEmpty);
  endtask

  task automatic inPlaceUpdate();
    heapOp       updateOps [5];
    logic [15:0] data;
    heapStatus   status;
    updateOps = '{opAdd, opSub, opAnd, opOr, opXor};
    for (int i = 0; i < 4; i++) begin
      busRequest(opWrite, 2, i, 16'($random(seed)), data, status);
    end
    for (int slot = 0; slot < 4; slot++) begin
      for (int k = 0; k < 5; k++) begin
        busRequest(updateOps[k], 2, slot, 16'($random(seed)), data, status);
        busRequest(opRead, 2, slot, '0, data, status);
        confirmReply("read after update", data, status, modelMem[2][slot], stOk);
      end
    end
    busRequest(opAdd, 2, 6, 16'h0001, data, status);  // Past the size
    confirmReply("add past size", data, status, '0, stOutOfBounds);
  endtask

  task automatic freedProtection();
    heapOp       deadOps [11];
    logic [15:0] data;
    heapStatus   status;
    deadOps = '{opFree, opWrite, opRead, opSize, opPush, opPop,
                opAdd, opSub, opAnd, opOr, opXor};
    busRequest(opFree, 3, 0, '0, data, status);
    confirmReply("free", data, status, '0, stOk);
    foreach (deadOps[k]) begin
      busRequest(deadOps[k], 3, 0, 16'($random(seed)), data, status);
      confirmReply("freed array", data, status, '0, stNotAllocated);
    end
    busRequest(opSize, 0, 0, '0, data, status);   // Other arrays unharmed
    busRequest(opRead, 0, 4, '0, data, status);
  endtask

  initial begin
    request      = '0;
    request.cyc  = 1'b1;                          // Pending alloc held through reset
    request.stb  = 1'b1;
    reset        = 1'b1;
    errorCount   = 0;
    requestCount = 0;
    nextFresh    = 0;
    expData      = '0;
    expStatus    = stOk;
    for (int n = 0; n < arrayCount; n++) begin
      modelLive[n] = 1'b0;
      modelSize[n] = 0;
    end
    repeat (3) @(posedge clock);
    #2;
    reset   = 1'b0;
    request = '0;
    allocationOrder();
    writeAndRead();
    pushAndPop();
    inPlaceUpdate();
    freedProtection();
    repeat (2) @(posedge clock);                  // Let the last ack be checked
    #1;
    $display("Requests: %0d, errors: %0d", requestCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/arrayHeap.sv
`timescale 1ns/1ns
`default_nettype none
// Array heap behind a Wishbone classic slave port
// arrayLimit caps allocation and must not exceed 2**arrayBits

module arrayHeap #(
  parameter int unsigned arrayLimit = 8
) (
  input  wire                    clock,
  input  wire                    reset,
  input  wire heapPkg::wbRequest request,
  output heapPkg::wbResponse     response
);

  import heapPkg::*;

  heapAddress          current;                   // Request being executed
  logic [dataBits-1:0] currentData;
  logic                execute;                   // One-cycle work strobe
  logic                arrayLive;
  allocReply           allocResult;
  accessVerdict        verdict;
  logic [sizeBits-1:0] arraySize;
  logic [dataBits-1:0] elementResult;

  heapBus i_heapBus (
    .clock         (clock),
    .reset         (reset),
    .request       (request),
    .response      (response),
    .current       (current),
    .currentData   (currentData),
    .execute       (execute),
    .allocResult   (allocResult),
    .verdict       (verdict),
    .arraySize     (arraySize),
    .elementResult (elementResult)
  );

  arrayAllocator #(
    .arrayLimit (arrayLimit)
  ) i_arrayAllocator (
    .clock       (clock),
    .reset       (reset),
    .current     (current),
    .execute     (execute),
    .arrayLive   (arrayLive),
    .allocResult (allocResult)
  );

  arraySizeTable i_arraySizeTable (
    .clock      (clock),
    .reset      (reset),
    .current    (current),
    .execute    (execute),
    .arrayLive  (arrayLive),
    .allocArray (allocResult),                    // Alloc clears the new array's size
    .verdict    (verdict),
    .arraySize  (arraySize)
  );

  elementStore i_elementStore (
    .clock         (clock),
    .current       (current),
    .currentData   (currentData),
    .verdict       (verdict),
    .elementResult (elementResult)
  );

endmodule

`default_nettype wire

//--- source/elementStore.sv
`timescale 1ns/1ns
`default_nettype none
// Element memory with a read-modify-write unit
// Arithmetic wraps modulo 2**dataBits; only commit allows a write

module elementStore (
  input  wire                          clock,
  input  wire heapPkg::heapAddress     current,
  input  wire [heapPkg::dataBits-1:0]  currentData,
  input  wire heapPkg::accessVerdict   verdict,
  output logic [heapPkg::dataBits-1:0] elementResult
);

  import heapPkg::*;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  logic [dataBits-1:0]            memory [arrayCount*arrayLength];  // Arrays in fixed blocks
  logic [arrayBits+indexBits-1:0] address;        // Array block plus element
  logic [dataBits-1:0]            stored;         // Element before the update

  assign address = {current.array, verdict.elementIndex};
  assign stored  = memory[address];

  // --------------------------------------------------
  // Update unit
  // --------------------------------------------------
  always_comb begin
    case (current.op)
      opWrite, opPush: elementResult = currentData;           // Plain store
      opAdd:           elementResult = stored + currentData;
      opSub:           elementResult = stored - currentData;
      opAnd:           elementResult = stored & currentData;
      opOr:            elementResult = stored | currentData;
      opXor:           elementResult = stored ^ currentData;
      default:         elementResult = stored;                // Read and pop
    endcase
  end

  // Write back only what the size table allowed
  always_ff @(posedge clock) begin
    if (verdict.commit) begin
      memory[address] <= elementResult;
    end
  end

endmodule

`default_nettype wire

//--- source/arraySizeTable.sv
`timescale 1ns/1ns
`default_nettype none
// Holds each array's size and decides whether an access is allowed
// Verdict is combinational during execute; sizes change at its end

module arraySizeTable (
  input  wire                          clock,
  input  wire                          reset,
  input  wire heapPkg::heapAddress     current,
  input  wire                          execute,
  input  wire                          arrayLive,
  input  wire heapPkg::allocReply      allocArray,
  output heapPkg::accessVerdict        verdict,
  output logic [heapPkg::sizeBits-1:0] arraySize
);

  import heapPkg::*;

  logic [sizeBits-1:0] sizes [arrayCount];        // Current size per array
  logic [sizeBits-1:0] sizeLess;                  // Size minus one
  logic [sizeBits-1:0] indexPlusOne;              // Size after a write
  logic                inBounds;                  // Index below size
  logic                writes;                    // Opcode updates an element

  assign arraySize    = sizes[current.array];
  assign sizeLess     = arraySize - 1'b1;
  assign indexPlusOne = {1'b0, current.index} + 1'b1;
  assign inBounds     = {1'b0, current.index} < arraySize;

  // --------------------------------------------------
  // Access check
  // --------------------------------------------------
  always_comb begin
    verdict = '{status: stOk, elementIndex: current.index, commit: 1'b0};
    writes  = 1'b0;
    if (current.op == opAlloc) begin
      verdict.status = allocArray.status;         // Only alloc can run out
    end else if (!arrayLive) begin
      verdict.status = stNotAllocated;            // Freed or never allocated
    end else begin
      case (current.op)
        opWrite: writes = 1'b1;
        opRead: begin
          if (!inBounds) verdict.status = stOutOfBounds;
        end
        opAdd, opSub, opAnd, opOr, opXor: begin
          if (!inBounds) verdict.status = stOutOfBounds;
          writes = 1'b1;
        end
        opPush: begin
          if (arraySize == sizeBits'(arrayLength)) verdict.status = stFull;
          verdict.elementIndex = arraySize[indexBits-1:0];  // Slot past the end
          writes               = 1'b1;
        end
        opPop: begin
          if (arraySize == '0) verdict.status = stEmpty;
          verdict.elementIndex = sizeLess[indexBits-1:0];   // Last element
        end
        default: ;                                // Size and free only need a live array
      endcase
    end
    verdict.commit = execute && writes && (verdict.status == stOk);
  end

  // --------------------------------------------------
  // Size update
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < arrayCount; n++) begin
        sizes[n] <= '0;
      end
    end else if (execute) begin
      if (current.op == opAlloc && allocArray.status == stOk) begin
        sizes[allocArray.array] <= '0;            // New array starts empty
      end else if (verdict.status == stOk) begin
        case (current.op)
          opWrite: begin
            if (indexPlusOne > arraySize) sizes[current.array] <= indexPlusOne;
          end
          opPush:  sizes[current.array] <= arraySize + 1'b1;
          opPop:   sizes[current.array] <= sizeLess;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- source/arrayAllocator.sv
`timescale 1ns/1ns
`default_nettype none
// Hands out array numbers; freed numbers come back last-in first-out
// arrayLimit must not exceed 2**arrayBits
// Free of a dead array is ignored here, the size table flags it

module arrayAllocator #(
  parameter int unsigned arrayLimit = heapPkg::arrayCount
) (
  input  wire                      clock,
  input  wire                      reset,
  input  wire heapPkg::heapAddress current,
  input  wire                      execute,
  output logic                     arrayLive,
  output heapPkg::allocReply       allocResult
);

  import heapPkg::*;

  logic [arrayCount-1:0] allocated;               // One bit per array
  logic [arrayBits-1:0]  freeStack [arrayCount];  // Freed numbers
  logic [arrayBits:0]    stackDepth;              // Entries on the stack
  logic [arrayBits:0]    stackTop;                // Depth minus one
  logic [arrayBits:0]    neverUsed;               // Next fresh number

  assign stackTop  = stackDepth - 1'b1;
  assign arrayLive = allocated[current.array];

  // --------------------------------------------------
  // Next number to hand out
  // --------------------------------------------------
  always_comb begin
    allocResult.array  = '0;
    allocResult.status = stOk;
    if (stackDepth != '0) begin
      allocResult.array = freeStack[stackTop[arrayBits-1:0]];  // Reuse latest freed
    end else if (32'(neverUsed) < arrayLimit) begin
      allocResult.array = neverUsed[arrayBits-1:0];            // Fresh number
    end else begin
      allocResult.status = stOutOfMemory;
    end
  end

  // --------------------------------------------------
  // State update at the end of execute
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated  <= '0;
      stackDepth <= '0;
      neverUsed  <= '0;
    end else if (execute) begin
      case (current.op)
        opAlloc: begin
          if (allocResult.status == stOk) begin
            allocated[allocResult.array] <= 1'b1;
            if (stackDepth != '0) begin
              stackDepth <= stackTop;             // Pop
            end else begin
              neverUsed <= neverUsed + 1'b1;
            end
          end
        end
        opFree: begin
          if (arrayLive) begin
            allocated[current.array]                <= 1'b0;
            freeStack[stackDepth[arrayBits-1:0]] <= current.array;  // Push
            stackDepth                              <= stackDepth + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/heapBus.sv
`timescale 1ns/1ns
`default_nettype none
// Wishbone classic slave, one request in flight at a time
// Ack comes one cycle after sampling and lasts one cycle; we is not decoded
// Requests are not sampled while execute or ack is high

module heapBus (
  input  wire                          clock,
  input  wire                          reset,
  input  wire heapPkg::wbRequest       request,
  output heapPkg::wbResponse           response,
  output heapPkg::heapAddress          current,
  output logic [heapPkg::dataBits-1:0] currentData,
  output logic                         execute,
  input  wire heapPkg::allocReply      allocResult,
  input  wire heapPkg::accessVerdict   verdict,
  input  wire [heapPkg::sizeBits-1:0]  arraySize,
  input  wire [heapPkg::dataBits-1:0]  elementResult
);

  import heapPkg::*;

  logic                accepted;                  // Request sampled this edge
  logic                ackReg;
  logic [dataBits-1:0] dataReg;                   // Registered reply payload
  heapStatus           statusReg;
  logic [dataBits-1:0] replyData;                 // Reply chosen by opcode

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign accepted = request.cyc && request.stb && !ackReg && !execute;

  always_ff @(posedge clock) begin
    if (reset) begin
      execute <= 1'b0;
      ackReg  <= 1'b0;
    end else begin
      execute <= accepted;                        // One cycle of work
      ackReg  <= execute;                         // Ack right after it
    end
  end

  // --------------------------------------------------
  // Request capture and reply payload
  // --------------------------------------------------
  always_comb begin
    case (current.op)
      opAlloc:        replyData = dataBits'(allocResult.array);
      opSize:         replyData = dataBits'(arraySize);
      opFree, opPush: replyData = '0;
      default:        replyData = elementResult;  // Element value after the update
    endcase
    if (verdict.status != stOk) begin
      replyData = '0;                             // No payload on errors
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      current     <= request.adr;
      currentData <= request.data;
    end
    if (execute) begin
      dataReg   <= replyData;
      statusReg <= verdict.status;
    end
  end

  assign response = '{ack: ackReg, data: dataReg, status: statusReg};

endmodule

`default_nettype wire

//--- source/heapPkg.sv
`default_nettype none
// Shared widths, opcodes, status codes and bus structs for the array heap
// Eight arrays of eight 16-bit elements; sizes run from 0 to 8 inclusive

package heapPkg;

  // --------------------------------------------------
  // Field widths
  // --------------------------------------------------
  localparam int arrayBits   = 3;                 // Array number width
  localparam int indexBits   = 3;                 // Element index width
  localparam int dataBits    = 16;                // Element width
  localparam int sizeBits    = indexBits + 1;     // Size counts up to the full length
  localparam int arrayCount  = 2 ** arrayBits;    // Arrays in the memory
  localparam int arrayLength = 2 ** indexBits;    // Elements per array

  // --------------------------------------------------
  // Opcodes and status
  // --------------------------------------------------
  typedef enum logic [3:0] {
    opAlloc, opFree, opWrite, opRead, opSize, opPush, opPop,
    opAdd, opSub, opAnd, opOr, opXor
  } heapOp;

  typedef enum logic [2:0] {
    stOk, stNotAllocated, stOutOfBounds, stFull, stEmpty, stOutOfMemory
  } heapStatus;

  // --------------------------------------------------
  // Bus and internal structs
  // --------------------------------------------------
  typedef struct packed {
    heapOp                op;                     // What to do
    logic [arrayBits-1:0] array;                  // Which array
    logic [indexBits-1:0] index;                  // Which element
  } heapAddress;                                  // Carried on the Wishbone address lines

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;                      // Not decoded, the opcode decides
    heapAddress          adr;
    logic [dataBits-1:0] data;
  } wbRequest;                                    // Master-driven signals

  typedef struct packed {
    logic                ack;
    logic [dataBits-1:0] data;
    heapStatus           status;
  } wbResponse;                                   // Slave-driven signals

  typedef struct packed {
    heapStatus            status;
    logic [indexBits-1:0] elementIndex;           // Element actually touched
    logic                 commit;                 // Element store may write
  } accessVerdict;

  typedef struct packed {
    logic [arrayBits-1:0] array;                  // Number handed out by alloc
    heapStatus            status;                 // stOk or stOutOfMemory
  } allocReply;

endpackage

`default_nettype wire
